/* logic/scope_pkg.sv */
/*
 * Shared definitions for the oscilloscope capture self-test.
 * Holds the register map, the sample word type and the reset values.
 */
package scope_pkg;

    // One captured sample as stored in the frame memory
    typedef logic [15:0] sample_t;

    // Host register address
    typedef logic [3:0] reg_addr_t;

    // Bit 0 of the control register is the enable level
    localparam reg_addr_t REG_CTRL = 4'd0;

    // Sampling period in clock cycles
    // Anything below 2 behaves as 2
    localparam reg_addr_t REG_PERIOD = 4'd1;

    // Any write here arms a new capture
    localparam reg_addr_t REG_ARM = 4'd2;

    // Read only, bit 0 reports a finished frame
    localparam reg_addr_t REG_STATUS = 4'd3;

    // Sampling period after reset
    localparam logic [31:0] PERIOD_RESET = 32'd4;

    // Offset between neighbouring channels in the synthetic pattern
    localparam int unsigned CHANNEL_SCALE = 100;

endpackage

/* logic/scope_control.sv */
/*
 * Host register file of the capture self-test.
 * Turns single-cycle writes into enable, period and arm, and reports the done flag.
 */
`timescale 1ns/1ps

module scope_control #(
    parameter int COUNTER_WIDTH = 32
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     reg_write,
    input  scope_pkg::reg_addr_t     reg_addr,
    input  logic [31:0]              reg_wdata,
    output logic [31:0]              reg_rdata,
    input  logic                     frame_done,
    output logic                     enable,
    output logic [COUNTER_WIDTH-1:0] period,
    output logic                     arm
);
    import scope_pkg::*;

    logic done;

    // Enable and period take the new value at the write edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable <= 1'b0;
            period <= COUNTER_WIDTH'(PERIOD_RESET);
        end else if (reg_write) begin
            if (reg_addr == REG_CTRL) begin
                enable <= reg_wdata[0];
            end
            if (reg_addr == REG_PERIOD) begin
                period <= COUNTER_WIDTH'(reg_wdata);
            end
        end
    end

    // The data written to the arm register does not matter
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            arm <= 1'b0;
        end else begin
            arm <= reg_write && (reg_addr == REG_ARM);
        end
    end

    // Done holds from the end of a frame until the host arms again
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (arm) begin
            done <= 1'b0;
        end else if (frame_done) begin
            done <= 1'b1;
        end
    end

    always_comb begin
        case (reg_addr)
            REG_CTRL: begin
                reg_rdata = {31'd0, enable};
            end
            REG_PERIOD: begin
                reg_rdata = 32'(period);
            end
            REG_STATUS: begin
                reg_rdata = {31'd0, done};
            end
            default: begin
                reg_rdata = 32'd0;
            end
        endcase
    end

endmodule

/* logic/sample_timebase.sv */
/*
 * Sampling strobe generator with a programmable period.
 * Fires one single-cycle strobe every period clock cycles while enabled.
 */
`timescale 1ns/1ps

module sample_timebase #(
    parameter int COUNTER_WIDTH = 32
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     enable,
    input  logic [COUNTER_WIDTH-1:0] period,
    output logic                     sample_strobe
);

    logic [COUNTER_WIDTH-1:0] count;
    logic [COUNTER_WIDTH-1:0] terminal_count;

    // A period of 0 or 1 would leave the strobe high, so clamp to 2
    always_comb begin
        if (period < COUNTER_WIDTH'(2)) begin
            terminal_count = COUNTER_WIDTH'(1);
        end else begin
            terminal_count = period - COUNTER_WIDTH'(1);
        end
    end

    // The compare is >= so that a shorter period written mid-count still wraps
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count         <= '0;
            sample_strobe <= 1'b0;
        end else if (!enable) begin
            count         <= '0;
            sample_strobe <= 1'b0;
        end else if (count >= terminal_count) begin
            count         <= '0;
            sample_strobe <= 1'b1;
        end else begin
            count         <= count + 1'b1;
            sample_strobe <= 1'b0;
        end
    end

endmodule

/* logic/test_pattern_source.sv */
/*
 * Synthetic sample source for the capture path.
 * Walks the channels round-robin on each strobe and emits index plus 100 times channel.
 */
`timescale 1ns/1ps

module test_pattern_source #(
    parameter int NUM_CHANNELS = 6
) (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            enable,
    input  logic                            sample_strobe,
    output logic                            sample_valid,
    output logic [$clog2(NUM_CHANNELS)-1:0] sample_channel,
    output scope_pkg::sample_t              sample_data
);
    import scope_pkg::*;

    localparam int CHANNEL_WIDTH = $clog2(NUM_CHANNELS);
    localparam logic [CHANNEL_WIDTH-1:0] LAST_CHANNEL = CHANNEL_WIDTH'(NUM_CHANNELS - 1);

    logic [CHANNEL_WIDTH-1:0] channel_count;
    logic [10:0]              sample_index;

    // Counters sit at zero while disabled so a fresh run starts at channel 0, index 0
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid  <= 1'b0;
            channel_count <= '0;
            sample_index  <= '0;
        end else if (!enable) begin
            sample_valid  <= 1'b0;
            channel_count <= '0;
            sample_index  <= '0;
        end else begin
            sample_valid <= sample_strobe;
            if (sample_strobe) begin
                if (channel_count == LAST_CHANNEL) begin
                    channel_count <= '0;
                    sample_index  <= sample_index + 1'b1;
                end else begin
                    channel_count <= channel_count + 1'b1;
                end
            end
        end
    end

    // Payload is only looked at when sample_valid is high
    always_ff @(posedge clock) begin
        if (sample_strobe) begin
            sample_channel <= channel_count;
            sample_data    <= sample_t'(32'(sample_index) + CHANNEL_SCALE * 32'(channel_count));
        end
    end

endmodule

/* logic/capture_buffer.sv */
/*
 * Armed single-frame capture into a channel-major sample memory.
 * Pulses frame_done after the last word and serves read-back through a registered port.
 */
`timescale 1ns/1ps

module capture_buffer #(
    parameter int NUM_CHANNELS    = 6,
    parameter int CHANNEL_SAMPLES = 16
) (
    input  logic                                            clock,
    input  logic                                            arst_n,
    input  logic                                            arm,
    input  logic                                            sample_valid,
    input  logic [$clog2(NUM_CHANNELS)-1:0]                 sample_channel,
    input  scope_pkg::sample_t                              sample_data,
    input  logic [$clog2(NUM_CHANNELS*CHANNEL_SAMPLES)-1:0] mem_addr,
    output scope_pkg::sample_t                              mem_rdata,
    output logic                                            frame_done
);
    import scope_pkg::*;

    localparam int DEPTH         = NUM_CHANNELS * CHANNEL_SAMPLES;
    localparam int ADDR_WIDTH    = $clog2(DEPTH);
    localparam int CHANNEL_WIDTH = $clog2(NUM_CHANNELS);
    localparam int INDEX_WIDTH   = $clog2(CHANNEL_SAMPLES);

    localparam logic [CHANNEL_WIDTH-1:0] LAST_CHANNEL = CHANNEL_WIDTH'(NUM_CHANNELS - 1);
    localparam logic [INDEX_WIDTH-1:0]   LAST_INDEX   = INDEX_WIDTH'(CHANNEL_SAMPLES - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,
        ST_CAPTURE
    } state_t;

    state_t                 state;
    logic [INDEX_WIDTH-1:0] sample_index;
    logic                   write_en;
    logic                   last_write;
    logic [ADDR_WIDTH-1:0]  write_addr;

    sample_t memory [DEPTH];

    // A frame only starts on channel 0 so that every row of the memory lines up
    always_comb begin
        write_en = sample_valid &&
                   ((state == ST_CAPTURE) ||
                    ((state == ST_ARMED) && (sample_channel == '0)));
        last_write = write_en &&
                     (sample_channel == LAST_CHANNEL) &&
                     (sample_index == LAST_INDEX);
        write_addr = ADDR_WIDTH'(sample_channel) * ADDR_WIDTH'(CHANNEL_SAMPLES) +
                     ADDR_WIDTH'(sample_index);
    end

    // The per-channel index advances once the last channel of a round is stored
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ST_IDLE;
            sample_index <= '0;
            frame_done   <= 1'b0;
        end else begin
            frame_done <= last_write && !arm;
            if (arm) begin
                state        <= ST_ARMED;
                sample_index <= '0;
            end else if (write_en) begin
                if (last_write) begin
                    state <= ST_IDLE;
                end else begin
                    state <= ST_CAPTURE;
                end
                if (sample_channel == LAST_CHANNEL) begin
                    sample_index <= sample_index + 1'b1;
                end
            end
        end
    end

    // Read-back is independent of the capture state and may run at any time
    always_ff @(posedge clock) begin
        if (write_en) begin
            memory[write_addr] <= sample_data;
        end
        mem_rdata <= memory[mem_addr];
    end

endmodule

/* logic/scope_test_top.sv */
/*
 * Top level of the oscilloscope capture self-test.
 * Wires the register file, timebase, pattern source and capture buffer together.
 */
`timescale 1ns/1ps

module scope_test_top #(
    parameter int NUM_CHANNELS    = 6,
    parameter int CHANNEL_SAMPLES = 16,
    parameter int COUNTER_WIDTH   = 32
) (
    input  logic                                            clock,
    input  logic                                            arst_n,
    input  logic                                            reg_write,
    input  scope_pkg::reg_addr_t                            reg_addr,
    input  logic [31:0]                                     reg_wdata,
    output logic [31:0]                                     reg_rdata,
    input  logic [$clog2(NUM_CHANNELS*CHANNEL_SAMPLES)-1:0] mem_addr,
    output scope_pkg::sample_t                              mem_rdata,
    output logic                                            dma_done
);
    import scope_pkg::*;

    localparam int CHANNEL_WIDTH = $clog2(NUM_CHANNELS);

    logic                     enable;
    logic [COUNTER_WIDTH-1:0] period;
    logic                     arm;
    logic                     sample_strobe;
    logic                     sample_valid;
    logic [CHANNEL_WIDTH-1:0] sample_channel;
    sample_t                  sample_data;

    scope_control #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) scope_control_i (
        .clock(clock),
        .arst_n(arst_n),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .frame_done(dma_done),
        .enable(enable),
        .period(period),
        .arm(arm)
    );

    sample_timebase #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) sample_timebase_i (
        .clock(clock),
        .arst_n(arst_n),
        .enable(enable),
        .period(period),
        .sample_strobe(sample_strobe)
    );

    test_pattern_source #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) test_pattern_source_i (
        .clock(clock),
        .arst_n(arst_n),
        .enable(enable),
        .sample_strobe(sample_strobe),
        .sample_valid(sample_valid),
        .sample_channel(sample_channel),
        .sample_data(sample_data)
    );

    // The frame done pulse doubles as the host-facing DMA done
    capture_buffer #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .CHANNEL_SAMPLES(CHANNEL_SAMPLES)
    ) capture_buffer_i (
        .clock(clock),
        .arst_n(arst_n),
        .arm(arm),
        .sample_valid(sample_valid),
        .sample_channel(sample_channel),
        .sample_data(sample_data),
        .mem_addr(mem_addr),
        .mem_rdata(mem_rdata),
        .frame_done(dma_done)
    );

endmodule

/* tb/tb_clock_gen.sv */
/*
 * Clock and reset source for the capture self-test bench.
 * Gives a 10 ns clock and holds arst_n low for the first 4 cycles.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // Release happens on a falling edge, away from the active clock edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

/* tb/tb_scope_checker.sv */
/*
 * Read-back checker for the capture self-test.
 * Compares every memory word the bench reads against the channel pattern and counts errors.
 */
`timescale 1ns/1ps

module tb_scope_checker #(
    parameter int NUM_CHANNELS    = 6,
    parameter int CHANNEL_SAMPLES = 16
) (
    input logic                                            clock,
    input logic                                            read_en,
    input logic [$clog2(NUM_CHANNELS*CHANNEL_SAMPLES)-1:0] mem_addr,
    input scope_pkg::sample_t                              mem_rdata
);
    localparam int ADDR_WIDTH = $clog2(NUM_CHANNELS * CHANNEL_SAMPLES);

    string                 test_name = "none";
    int                    mismatch_count = 0;
    int                    failure_count = 0;
    int                    words_checked = 0;
    logic                  pending = 1'b0;
    logic [ADDR_WIDTH-1:0] pending_addr = '0;

    // Channel c at index k holds k plus 100 times c, kept to 16 bits
    function automatic logic [15:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
        int unsigned channel;
        int unsigned index;
        channel = 32'(addr) / CHANNEL_SAMPLES;
        index   = 32'(addr) % CHANNEL_SAMPLES;
        return 16'(index + 100 * channel);
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
    endtask

    task automatic compare_value(input string what, input int expected, input int actual);
        if (actual != expected) begin
            mismatch_count++;
            $display("mismatch test=%s check=%s expected=%0d actual=%0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("error in test %s: %s", test_name, what);
    endtask

    // The read port has one cycle of latency, so remember what was asked for
    always @(posedge clock) begin
        pending      <= read_en;
        pending_addr <= mem_addr;
    end

    always @(negedge clock) begin
        if (pending) begin
            words_checked++;
            if (mem_rdata !== expected_word(pending_addr)) begin
                mismatch_count++;
                $display("mismatch test=%s addr=%0d expected=%0d actual=%0d",
                         test_name, pending_addr, expected_word(pending_addr), mem_rdata);
            end
        end
    end

endmodule

/* tb/tb_scope_top.sv */
/*
 * Top testbench of the capture self-test.
 * Runs a table of sampling periods, waits for each frame and reads the memory back.
 */
`timescale 1ns/1ps

module tb_scope_top;
    import scope_pkg::*;

    localparam int NUM_CHANNELS    = 6;
    localparam int CHANNEL_SAMPLES = 16;
    localparam int DEPTH           = NUM_CHANNELS * CHANNEL_SAMPLES;
    localparam int ADDR_WIDTH      = $clog2(DEPTH);
    localparam int NUM_ROWS        = 5;
    localparam int DONE_TIMEOUT    = 4000;
    localparam int RESET_TIMEOUT   = 50;

    logic                  clock;
    logic                  arst_n;
    logic                  reg_write;
    reg_addr_t             reg_addr;
    logic [31:0]           reg_wdata;
    logic [31:0]           reg_rdata;
    logic [ADDR_WIDTH-1:0] mem_addr;
    sample_t               mem_rdata;
    logic                  dma_done;
    logic                  read_en;

    // Row 3 gets a random period at the start of the run
    string       row_name [NUM_ROWS] = '{"period_2", "period_3", "period_7",
                                         "period_random", "period_0_clamped"};
    int unsigned row_period [NUM_ROWS] = '{2, 3, 7, 2, 0};
    bit          row_done [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    int unsigned rand_seed = 32'hb36e6baf;

    tb_clock_gen clock_gen_i (
        .clock(clock),
        .arst_n(arst_n)
    );

    scope_test_top #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .CHANNEL_SAMPLES(CHANNEL_SAMPLES),
        .COUNTER_WIDTH(32)
    ) scope_test_top_i (
        .clock(clock),
        .arst_n(arst_n),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .mem_addr(mem_addr),
        .mem_rdata(mem_rdata),
        .dma_done(dma_done)
    );

    tb_scope_checker #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .CHANNEL_SAMPLES(CHANNEL_SAMPLES)
    ) scope_checker_i (
        .clock(clock),
        .read_en(read_en),
        .mem_addr(mem_addr),
        .mem_rdata(mem_rdata)
    );

    // All tasks start and end just after a falling edge
    task automatic write_register(input reg_addr_t addr, input logic [31:0] data);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    task automatic read_register(input reg_addr_t addr, output logic [31:0] data);
        reg_addr = addr;
        @(negedge clock);
        data = reg_rdata;
    endtask

    // Done lasts one cycle, so every falling edge is looked at
    task automatic wait_for_done(input int limit, output bit seen);
        int i;
        seen = 1'b0;
        for (i = 0; i < limit && !seen; i++) begin
            @(negedge clock);
            seen = dma_done;
        end
    endtask

    task automatic read_back_frame();
        int a;
        read_en = 1'b1;
        for (a = 0; a < DEPTH; a++) begin
            mem_addr = ADDR_WIDTH'(a);
            @(negedge clock);
        end
        read_en = 1'b0;
        @(negedge clock);
    endtask

    task automatic run_table_row(input int r);
        logic [31:0] data;
        bit          seen;
        scope_checker_i.begin_test(row_name[r]);
        write_register(REG_CTRL, 32'd0);
        write_register(REG_PERIOD, row_period[r]);
        read_register(REG_PERIOD, data);
        scope_checker_i.compare_value("period readback", int'(row_period[r]), int'(data));
        write_register(REG_ARM, 32'd1);
        read_register(REG_STATUS, data);
        scope_checker_i.compare_value("status after arm", 0, int'(data[0]));
        write_register(REG_CTRL, 32'd1);
        wait_for_done(DONE_TIMEOUT, seen);
        if (row_done[r] && !seen) begin
            scope_checker_i.report_failure($sformatf("no done pulse within %0d cycles",
                                                     DONE_TIMEOUT));
        end else if (!row_done[r] && seen) begin
            scope_checker_i.report_failure("done pulse although the row expects none");
        end
        if (seen) begin
            read_register(REG_STATUS, data);
            scope_checker_i.compare_value("status after done", 1, int'(data[0]));
        end
        read_back_frame();
    endtask

    initial begin
        logic [31:0] data;
        bit          seen;
        int          i;
        int          errors;
        reg_write = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        mem_addr  = '0;
        read_en   = 1'b0;
        void'($urandom(rand_seed));
        row_period[3] = 2 + ($urandom % 8);

        for (i = 0; i < RESET_TIMEOUT && arst_n !== 1'b1; i++) begin
            @(negedge clock);
        end
        if (arst_n !== 1'b1) begin
            scope_checker_i.report_failure("reset was never released");
        end

        scope_checker_i.begin_test("reset_values");
        read_register(REG_CTRL, data);
        scope_checker_i.compare_value("ctrl after reset", 0, int'(data));
        read_register(REG_PERIOD, data);
        scope_checker_i.compare_value("period after reset", 4, int'(data));
        read_register(REG_STATUS, data);
        scope_checker_i.compare_value("status after reset", 0, int'(data));
        wait_for_done(20, seen);
        scope_checker_i.compare_value("done while disabled", 0, int'(seen));

        for (i = 0; i < NUM_ROWS; i++) begin
            run_table_row(i);
        end

        // Keep sampling with no new arm, the stored frame must stay as it was
        scope_checker_i.begin_test("hold_without_arm");
        wait_for_done(300, seen);
        scope_checker_i.compare_value("done without arm", 0, int'(seen));
        read_back_frame();

        errors = scope_checker_i.mismatch_count + scope_checker_i.failure_count;
        $display("checked %0d words, %0d mismatches, %0d other errors",
                 scope_checker_i.words_checked, scope_checker_i.mismatch_count,
                 scope_checker_i.failure_count);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* scope_test.f */
logic/scope_pkg.sv
logic/scope_control.sv
logic/sample_timebase.sv
logic/test_pattern_source.sv
logic/capture_buffer.sv
logic/scope_test_top.sv
tb/tb_clock_gen.sv
tb/tb_scope_checker.sv
tb/tb_scope_top.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --timescale 1ns/1ps
TOP       := tb_scope_top
FILELIST  := scope_test.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
